// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := fetch_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/cache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module cache_refill
    import fetch_pkg::*;
(
    input  wire                   clk_i,
    input  wire                   rst_i,
    input  wire                   refill_req_i,
    input  wire fetch_addr_t      refill_addr_i,
    input  wire cache_line_t      line_i,
    input  wire                   line_valid_i,
    output logic                  rd_o,
    output logic [MEM_LINE_W-1:0] rd_line_o,
    output cache_fill_t           fill_o,
    output logic                  refill_done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FILL
    } state_t;

    state_t state_q;

    logic [IDX_W-1:0]       index_q;
    logic [TAG_W-1:0]       tag_q;
    cache_line_t            line_q;
    logic [TAG_W+IDX_W-1:0] line_addr;

    // the memory line number is the low part of tag and index.
    assign line_addr = {refill_addr_i.tag, refill_addr_i.index};

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_IDLE;
            rd_o    <= 1'b0;
        end else begin
            rd_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (refill_req_i) begin
                        rd_o    <= 1'b1;
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (line_valid_i) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && refill_req_i) begin
            index_q   <= refill_addr_i.index;
            tag_q     <= refill_addr_i.tag;
            rd_line_o <= line_addr[MEM_LINE_W-1:0];
        end
        if (line_valid_i) begin
            line_q <= line_i;
        end
    end

    assign fill_o = '{valid: (state_q == ST_FILL), index: index_q, tag: tag_q, line: line_q};
    assign refill_done_o = (state_q == ST_FILL);

    // the fetch unit stalls until refill_done, so requests never overlap.
    req_when_idle_a : assert property (@(posedge clk_i) disable iff (!rst_i)
        refill_req_i |-> (state_q == ST_IDLE));

endmodule

`default_nettype wire

// File: source/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// cache geometry, each line holds four 32-bit words.
`define FETCH_CACHE_LINES 256

// backing memory size in lines, addressed by bits 13 to 4 of the byte address.
`define FETCH_MEM_LINES 1024

// cycles from a line read strobe to the line being valid.
`define FETCH_MEM_LATENCY 4

`endif

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    localparam int unsigned IDX_W      = $clog2(`FETCH_CACHE_LINES);
    localparam int unsigned TAG_W      = 32 - IDX_W - 4;
    localparam int unsigned MEM_LINE_W = $clog2(`FETCH_MEM_LINES);

    // byte address as the cache sees it.
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [1:0]       word_sel;
        logic [1:0]       byte_off;
    } fetch_addr_t;

    // word 0 sits in the low 32 bits.
    typedef logic [3:0][31:0] cache_line_t;

    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] index;
        logic [TAG_W-1:0] tag;
    } cache_lookup_t;

    typedef struct packed {
        logic             valid;
        logic [IDX_W-1:0] index;
        logic [TAG_W-1:0] tag;
        cache_line_t      line;
    } cache_fill_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         start_i,
    input  wire [31:0]  start_pc_i,
    input  wire [15:0]  count_i,
    input  wire         flush_i,
    input  wire         mem_wr_i,
    input  wire [31:0]  mem_wr_addr_i,
    input  wire [31:0]  mem_wr_data_i,
    output fetch_out_t  fetch_o,
    output logic        busy_o
);

    cache_lookup_t         lookup;
    logic [1:0]            word_sel;
    logic [31:0]           cache_word;
    logic                  cache_hit;
    logic                  refill_req;
    fetch_addr_t           refill_addr;
    logic                  refill_done;
    cache_fill_t           fill;
    logic                  mem_rd;
    logic [MEM_LINE_W-1:0] mem_rd_line;
    cache_line_t           mem_line;
    logic                  mem_line_valid;

    fetch_unit u_fetch_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .start_pc_i    (start_pc_i),
        .count_i       (count_i),
        .word_i        (cache_word),
        .hit_i         (cache_hit),
        .refill_done_i (refill_done),
        .lookup_o      (lookup),
        .word_sel_o    (word_sel),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .fetch_o       (fetch_o),
        .busy_o        (busy_o)
    );

    instr_cache u_instr_cache (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .lookup_i   (lookup),
        .word_sel_i (word_sel),
        .fill_i     (fill),
        .flush_i    (flush_i),
        .word_o     (cache_word),
        .hit_o      (cache_hit)
    );

    cache_refill u_cache_refill (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .line_i        (mem_line),
        .line_valid_i  (mem_line_valid),
        .rd_o          (mem_rd),
        .rd_line_o     (mem_rd_line),
        .fill_o        (fill),
        .refill_done_o (refill_done)
    );

    line_memory u_line_memory (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_i         (mem_wr_i),
        .wr_addr_i    (mem_wr_addr_i),
        .wr_data_i    (mem_wr_data_i),
        .rd_i         (mem_rd),
        .rd_line_i    (mem_rd_line),
        .line_o       (mem_line),
        .line_valid_o (mem_line_valid)
    );

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  start_i,
    input  wire [31:0]           start_pc_i,
    input  wire [15:0]           count_i,
    input  wire [31:0]           word_i,
    input  wire                  hit_i,
    input  wire                  refill_done_i,
    output cache_lookup_t        lookup_o,
    output logic [1:0]           word_sel_o,
    output logic                 refill_req_o,
    output fetch_addr_t          refill_addr_o,
    output fetch_out_t           fetch_o,
    output logic                 busy_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_MISS
    } state_t;

    state_t state_q;

    logic [31:0] issue_pc_q;
    logic [31:0] resp_pc_q;
    logic        resp_valid_q;
    logic [15:0] issue_left_q;
    logic [15:0] retire_left_q;

    fetch_addr_t issue_addr;
    logic        hit_now;
    logic        miss_now;
    logic        issue_now;

    assign issue_addr = issue_pc_q;

    // the cache answers the lookup issued in the previous cycle.
    assign hit_now  = resp_valid_q && hit_i;
    assign miss_now = resp_valid_q && !hit_i;

    // on a miss the lookup that would follow it is dropped.
    assign issue_now = (state_q == ST_RUN) && (issue_left_q != '0) && !miss_now;

    assign lookup_o   = '{valid: issue_now, index: issue_addr.index, tag: issue_addr.tag};
    assign word_sel_o = issue_addr.word_sel;

    assign refill_req_o  = miss_now;
    assign refill_addr_o = resp_pc_q;

    assign fetch_o = '{valid: hit_now, pc: resp_pc_q, instr: word_i};
    assign busy_o  = (state_q != ST_IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q       <= ST_IDLE;
            resp_valid_q  <= 1'b0;
            issue_left_q  <= '0;
            retire_left_q <= '0;
        end else begin
            resp_valid_q <= issue_now;
            case (state_q)
                ST_IDLE: begin
                    if (start_i && count_i != '0) begin
                        state_q       <= ST_RUN;
                        issue_left_q  <= count_i;
                        retire_left_q <= count_i;
                    end
                end
                ST_RUN: begin
                    if (issue_now) begin
                        issue_left_q <= issue_left_q - 1'b1;
                    end
                    if (miss_now) begin
                        // replay restarts issue from the missed word.
                        state_q      <= ST_MISS;
                        issue_left_q <= retire_left_q;
                    end else if (hit_now) begin
                        retire_left_q <= retire_left_q - 1'b1;
                        if (retire_left_q == 16'd1) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_MISS: begin
                    if (refill_done_i) begin
                        state_q <= ST_RUN;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            issue_pc_q <= start_pc_i;
        end else if (miss_now) begin
            issue_pc_q <= resp_pc_q;
        end else if (issue_now) begin
            issue_pc_q <= issue_pc_q + 32'd4;
        end
        if (issue_now) begin
            resp_pc_q <= issue_pc_q;
        end
    end

    // the refill path answers a miss after the memory latency plus two cycles.
    refill_latency_a : assert property (@(posedge clk_i) disable iff (!rst_i)
        refill_req_o |-> ##(`FETCH_MEM_LATENCY + 2) refill_done_i);

endmodule

`default_nettype wire

// File: source/instr_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module instr_cache
    import fetch_pkg::*;
(
    input  wire                clk_i,
    input  wire                rst_i,
    input  wire cache_lookup_t lookup_i,
    input  wire [1:0]          word_sel_i,
    input  wire cache_fill_t   fill_i,
    input  wire                flush_i,
    output logic [31:0]        word_o,
    output logic               hit_o
);

    cache_line_t                   data_mem [`FETCH_CACHE_LINES];
    logic [TAG_W-1:0]              tag_mem  [`FETCH_CACHE_LINES];
    logic [`FETCH_CACHE_LINES-1:0] valid_q;

    logic tag_match;

    assign tag_match = valid_q[lookup_i.index] && (tag_mem[lookup_i.index] == lookup_i.tag);

    // line data and tags.
    // a fill has priority, so no word is read in a fill cycle.
    always_ff @(posedge clk_i) begin
        if (fill_i.valid) begin
            data_mem[fill_i.index] <= fill_i.line;
            tag_mem[fill_i.index]  <= fill_i.tag;
        end else if (lookup_i.valid) begin
            word_o <= data_mem[lookup_i.index][word_sel_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            hit_o   <= 1'b0;
        end else begin
            if (flush_i) begin
                valid_q <= '0;
            end
            // a fill in the flush cycle still leaves its own line valid.
            if (fill_i.valid) begin
                valid_q[fill_i.index] <= 1'b1;
                hit_o                 <= 1'b0;
            end else begin
                hit_o <= lookup_i.valid && tag_match;
            end
        end
    end

    // the fetch unit only refills while stalled, so it never looks up then.
    fill_lookup_excl_a : assert property (@(posedge clk_i) disable iff (!rst_i)
        !(fill_i.valid && lookup_i.valid));

endmodule

`default_nettype wire

// File: source/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module line_memory
    import fetch_pkg::*;
(
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  wr_i,
    input  wire [31:0]           wr_addr_i,
    input  wire [31:0]           wr_data_i,
    input  wire                  rd_i,
    input  wire [MEM_LINE_W-1:0] rd_line_i,
    output cache_line_t          line_o,
    output logic                 line_valid_o
);

    localparam int unsigned CNT_W = $clog2(`FETCH_MEM_LATENCY + 1);

    cache_line_t mem_q [`FETCH_MEM_LINES];

    logic [MEM_LINE_W-1:0] wr_line;
    logic [1:0]            wr_word;
    cache_line_t           line_q;
    logic [CNT_W-1:0]      cnt_q;

    assign wr_line = wr_addr_i[MEM_LINE_W+3:4];
    assign wr_word = wr_addr_i[3:2];

    // word writes from the preload port, line reads for refills.
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_q[wr_line][wr_word] <= wr_data_i;
        end
        if (rd_i) begin
            line_q <= mem_q[rd_line_i];
        end
    end

    // the countdown runs from the latency down to one.
    // the line is presented in the cycle where it reads one.
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else if (rd_i) begin
            cnt_q <= CNT_W'(`FETCH_MEM_LATENCY);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign line_o       = line_q;
    assign line_valid_o = (cnt_q == CNT_W'(1));

    // one read at a time, the refill controller waits for the line.
    single_read_a : assert property (@(posedge clk_i) disable iff (!rst_i)
        rd_i |-> (cnt_q == '0));

endmodule

`default_nettype wire

// File: tb/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int unsigned MEM_WORDS       = `FETCH_MEM_LINES * 4;
    localparam int unsigned CYCLES_PER_WORD = 16;

    logic        clk_i;
    logic        rst_i;
    logic        start_i;
    logic [31:0] start_pc_i;
    logic [15:0] count_i;
    logic        flush_i;
    logic        mem_wr_i;
    logic [31:0] mem_wr_addr_i;
    logic [31:0] mem_wr_data_i;
    fetch_out_t  fetch_o;
    logic        busy_o;

    // a copy of the memory and a model of the lines that the cache holds.
    logic [31:0]                   mem_copy   [MEM_WORDS];
    logic [31:0]                   model_data [`FETCH_CACHE_LINES][4];
    logic [TAG_W-1:0]              model_tag  [`FETCH_CACHE_LINES];
    logic [`FETCH_CACHE_LINES-1:0] model_valid;

    integer      seed;
    logic [31:0] run_pc           = 32'd0;
    logic [15:0] run_count        = 16'd0;
    logic [15:0] pulse_base       = 16'd0;
    logic [15:0] pulse_total      = 16'd0;
    int unsigned run_cycles;
    int unsigned fetch_mismatches = 0;
    int unsigned done_mismatches  = 0;
    int unsigned stray_pulses     = 0;
    int unsigned run_errors       = 0;

    fetch_top dut0 (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .start_pc_i    (start_pc_i),
        .count_i       (count_i),
        .flush_i       (flush_i),
        .mem_wr_i      (mem_wr_i),
        .mem_wr_addr_i (mem_wr_addr_i),
        .mem_wr_data_i (mem_wr_data_i),
        .fetch_o       (fetch_o),
        .busy_o        (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    // a word comes from the cached line if the model holds it, else from memory.
    function automatic logic [31:0] ref_word(input logic [31:0] pc);
        logic [IDX_W-1:0] idx;
        idx = pc[IDX_W+3:4];
        if (model_valid[idx] && model_tag[idx] == pc[31:IDX_W+4]) begin
            return model_data[idx][pc[3:2]];
        end
        return mem_copy[pc[13:2]];
    endfunction

    function automatic fetch_out_t expected_out(input logic [31:0] pc);
        fetch_out_t want;
        want.valid = 1'b1;
        want.pc    = pc;
        want.instr = ref_word(pc);
        return want;
    endfunction

    // a retired word means its line was resident, so install it on a model miss.
    task automatic model_fill(input logic [31:0] pc);
        logic [IDX_W-1:0] idx;
        idx = pc[IDX_W+3:4];
        if (!(model_valid[idx] && model_tag[idx] == pc[31:IDX_W+4])) begin
            for (int w = 0; w < 4; w++) begin
                model_data[idx][2'(w)] = mem_copy[{pc[13:4], 2'(w)}];
            end
            model_tag[idx]   = pc[31:IDX_W+4];
            model_valid[idx] = 1'b1;
        end
    endtask

    task automatic check_fetch(input fetch_out_t got, input fetch_out_t want);
        if (got.pc !== want.pc) begin
            $display("MISMATCH at time %0t: pc %h, expected %h", $time, got.pc, want.pc);
            fetch_mismatches++;
        end else if (got.instr !== want.instr) begin
            $display("MISMATCH at time %0t: instr %h at pc %h, expected %h",
                     $time, got.instr, got.pc, want.instr);
            fetch_mismatches++;
        end
    endtask

    task automatic compare_done(input logic busy, input logic [15:0] pulses,
                                input logic [15:0] want_pulses);
        if (busy !== 1'b0) begin
            $display("MISMATCH at time %0t: busy_o is %b while idle expected", $time, busy);
            done_mismatches++;
        end
        if (pulses !== want_pulses) begin
            $display("MISMATCH at time %0t: %0d instruction pulses, expected %0d",
                     $time, pulses, want_pulses);
            done_mismatches++;
        end
    endtask

    // every pulse is checked against the next pc of the run and the model.
    always @(posedge clk_i) begin
        logic [15:0] seen;
        logic [31:0] pc;
        seen = pulse_total - pulse_base;
        pc   = run_pc + {14'd0, seen, 2'b00};
        // reset and flush both clear every valid bit in the cache.
        if (!rst_i || flush_i) begin
            model_valid = '0;
        end
        if (rst_i && fetch_o.valid) begin
            if (seen >= run_count) begin
                $display("ERROR at time %0t: instruction pulse with no fetch outstanding",
                         $time);
                stray_pulses++;
            end else begin
                check_fetch(fetch_o, expected_out(pc));
                model_fill(pc);
            end
            pulse_total = pulse_total + 16'd1;
        end
    end

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        mem_wr_i             = 1'b1;
        mem_wr_addr_i        = addr;
        mem_wr_data_i        = data;
        mem_copy[addr[13:2]] = data;
    endtask

    task automatic end_writes();
        @(negedge clk_i);
        mem_wr_i = 1'b0;
    endtask

    task automatic pulse_flush();
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
    endtask

    task automatic wait_idle(input int unsigned limit, output int unsigned cycles);
        cycles = 0;
        while (busy_o && cycles < limit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            $display("ERROR at time %0t: fetch still busy after %0d cycles", $time, limit);
            run_errors++;
        end
    endtask

    task automatic run_fetch(input logic [31:0] pc, input logic [15:0] count);
        run_pc     = pc;
        run_count  = count;
        pulse_base = pulse_total;
        @(negedge clk_i);
        start_i    = 1'b1;
        start_pc_i = pc;
        count_i    = count;
        @(negedge clk_i);
        start_i = 1'b0;
        wait_idle(CYCLES_PER_WORD * count + 64, run_cycles);
        compare_done(busy_o, pulse_total - pulse_base, count);
    endtask

    initial begin
        logic [31:0] data;
        seed          = 32'hcad9;
        rst_i         = 1'b0;
        start_i       = 1'b0;
        start_pc_i    = 32'd0;
        count_i       = 16'd0;
        flush_i       = 1'b0;
        mem_wr_i      = 1'b0;
        mem_wr_addr_i = 32'd0;
        mem_wr_data_i = 32'd0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b1;

        // nothing moves after reset until a start arrives.
        repeat (4) begin
            @(negedge clk_i);
            compare_done(busy_o, pulse_total, 16'd0);
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            data = $random(seed);
            write_word(32'(i) << 2, data);
        end
        end_writes();
        compare_done(busy_o, pulse_total, 16'd0);

        run_fetch(32'h0000_0000, 16'd64);
        // the warm pass hits on every word and issues one lookup per cycle.
        run_fetch(32'h0000_0000, 16'd64);
        if (run_cycles > 64 + 4) begin
            $display("ERROR at time %0t: warm run took %0d cycles", $time, run_cycles);
            run_errors++;
        end

        run_fetch(32'h0000_0208, 16'd10);

        // both addresses share an index and differ by one in the tag.
        for (int k = 0; k < 3; k++) begin
            run_fetch(32'h0000_0100, 16'd4);
            run_fetch(32'h0000_1100, 16'd4);
        end

        for (int i = 0; i < 16; i++) begin
            data = $random(seed);
            write_word(32'(i) << 2, data);
        end
        end_writes();
        // stale lines are still served until the flush.
        run_fetch(32'h0000_0000, 16'd16);
        pulse_flush();
        run_fetch(32'h0000_0000, 16'd16);

        repeat (4) begin
            @(negedge clk_i);
            compare_done(busy_o, pulse_total - pulse_base, run_count);
        end

        $display("errors: %0d fetch mismatches, %0d completion mismatches, %0d stray, %0d run",
                 fetch_mismatches, done_mismatches, stray_pulses, run_errors);
        if (fetch_mismatches + done_mismatches + stray_pulses + run_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/fetch_pkg.sv
source/instr_cache.sv
source/line_memory.sv
source/cache_refill.sv
source/fetch_unit.sv
source/fetch_top.sv
tb/fetch_tb.sv
